//--- compile.f
hw/pi1_pkg.sv
hw/soc_map_pkg.sv
hw/pi1_if.sv
hw/rst_seq.sv
hw/pi1_decoder.sv
hw/devtbl.sv
hw/gpio.sv
hw/soc_top.sv
test/tb_soc.sv

//--- Makefile
# Verilator build and run for the SoC housekeeping testbench.

VERILATOR ?= verilator
TOP       ?= tb_soc
RTL_TOP   ?= soc_top
FLIST     ?= compile.f
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_soc.sv
//------------------------------
// Directed testbench for soc_top: clock, reset,
// PI1 bus tasks, typed compares and timeout.
//------------------------------

`timescale 1ns/100ps

module tb_soc;

	localparam int RST_CNTR_BITSZ      = 4;
	localparam int ACTIVITY_CNTR_BITSZ = 3;
	localparam int GPIOCOUNT           = 16;
	localparam int SEED                = 60765;
	// About 450 cycles of tests and reset windows, with wide slack.
	localparam int TIMEOUT_CYCLES = 3000;
	localparam int RELEASE_CYCLES = (1 << RST_CNTR_BITSZ) - 1;
	// First word past the GPIO window.
	localparam pi1_pkg::pi1_addr_t FIRST_UNMAPPED = 30'd20;

	typedef logic [GPIOCOUNT-1:0] gpio_vec_t;

	logic               clk;
	logic               rst_p;
	pi1_pkg::pi1_op_e   pi1_op;
	pi1_pkg::pi1_addr_t pi1_addr;
	pi1_pkg::pi1_data_t pi1_wdata;
	pi1_pkg::pi1_sel_t  pi1_sel;
	gpio_vec_t          gp_i;
	pi1_pkg::pi1_data_t pi1_data_o;
	logic               pi1_rdy_o;
	gpio_vec_t          gp_o;
	logic               gpio_irq_o;
	logic               sys_rst_o;
	logic               activity_o;

	gpio_vec_t          gp_model;
	gpio_vec_t          gp_in_model;
	pi1_pkg::pi1_addr_t burst_addr [8];
	pi1_pkg::pi1_data_t burst_exp [8];
	int                 err_cnt;
	int                 check_cnt;
	int                 test_cnt;
	int                 cycle_cnt;

	soc_top #(
		.RST_CNTR_BITSZ      (RST_CNTR_BITSZ),
		.ACTIVITY_CNTR_BITSZ (ACTIVITY_CNTR_BITSZ),
		.GPIOCOUNT           (GPIOCOUNT)
	) i_dut (
		.clk100mhz_i (clk),
		.rst_p       (rst_p),
		.pi1_op_i    (pi1_op),
		.pi1_addr_i  (pi1_addr),
		.pi1_data_i  (pi1_wdata),
		.pi1_sel_i   (pi1_sel),
		.gp_i        (gp_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.gp_o        (gp_o),
		.gpio_irq_o  (gpio_irq_o),
		.sys_rst_o   (sys_rst_o),
		.activity_o  (activity_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: tests still running after %0d cycles", cycle_cnt);
		$display("TB FAILED");
		$finish;
	end

	task check_data(input string name, input pi1_pkg::pi1_data_t exp,
		input pi1_pkg::pi1_data_t act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("ERR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task check_bit(input string name, input logic exp, input logic act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("ERR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task check_gpio(input string name, input gpio_vec_t exp, input gpio_vec_t act);
		check_cnt++;
		if (exp !== act) begin
			err_cnt++;
			$display("ERR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task expect_ready(input string name);
		check_cnt++;
		if (pi1_rdy_o !== 1'b1) begin
			err_cnt++;
			$display("%s: no ready in the cycle after the request", name);
		end
	endtask

	task finish_test(input string name, input int errs_at_start);
		test_cnt++;
		$display("%-10s done, %0d errors", name, err_cnt - errs_at_start);
	endtask

	// Table words: ID in bits 31:1 with the interrupt flag in bit 0, then map size.
	function automatic pi1_pkg::pi1_data_t table_word(input int w);
		case (w)
			1:       return {31'd7, 1'b0};
			2:       return 32'd16;
			3:       return {31'd6, 1'b1};
			4:       return 32'd4;
			5:       return {31'd0, 1'b0};
			6:       return 32'd1024;
			default: return 32'd0;
		endcase
	endfunction

	function automatic pi1_pkg::pi1_addr_t random_unmapped();
		pi1_pkg::pi1_addr_t a;
		a = pi1_pkg::pi1_addr_t'($urandom);
		if (a < FIRST_UNMAPPED) begin
			a = a + FIRST_UNMAPPED;
		end
		return a;
	endfunction

	// One-cycle strobe; the answer is sampled mid-cycle after the request edge.
	task issue_request(input string name, input pi1_pkg::pi1_op_e op,
		input pi1_pkg::pi1_addr_t a, input pi1_pkg::pi1_data_t d,
		input pi1_pkg::pi1_sel_t s, output pi1_pkg::pi1_data_t rd);
		@(posedge clk);
		pi1_op    <= op;
		pi1_addr  <= a;
		pi1_wdata <= d;
		pi1_sel   <= s;
		@(posedge clk);
		pi1_op <= pi1_pkg::PI1_OP_IDLE;
		@(negedge clk);
		expect_ready(name);
		rd = pi1_data_o;
	endtask

	task bus_write(input string name, input pi1_pkg::pi1_addr_t a,
		input pi1_pkg::pi1_data_t d, input pi1_pkg::pi1_sel_t s);
		pi1_pkg::pi1_data_t unused_rd;
		issue_request(name, pi1_pkg::PI1_OP_WRITE, a, d, s, unused_rd);
	endtask

	task bus_read(input string name, input pi1_pkg::pi1_addr_t a,
		output pi1_pkg::pi1_data_t rd);
		issue_request(name, pi1_pkg::PI1_OP_READ, a, '0, '0, rd);
	endtask

	task bus_swap(input string name, input pi1_pkg::pi1_addr_t a,
		input pi1_pkg::pi1_data_t d, output pi1_pkg::pi1_data_t rd);
		issue_request(name, pi1_pkg::PI1_OP_SWAP, a, d, 4'hF, rd);
	endtask

	// Reads in consecutive cycles; each answer must follow its request by one cycle.
	task run_burst(input string name, input int n, output int pulses, output int first);
		pulses = 0;
		first  = -1;
		for (int i = 0; i <= n + 1; i++) begin
			@(posedge clk);
			if (i < n) begin
				pi1_op   <= pi1_pkg::PI1_OP_READ;
				pi1_addr <= burst_addr[i];
			end else begin
				pi1_op <= pi1_pkg::PI1_OP_IDLE;
			end
			@(negedge clk);
			if (i > 0 && i <= n) begin
				expect_ready(name);
				check_data(name, burst_exp[i-1], pi1_data_o);
			end else begin
				check_bit(name, 1'b0, pi1_rdy_o);
			end
			if (activity_o === 1'b1) begin
				pulses++;
				if (first < 0) begin
					first = i - 1;
				end
			end
		end
	endtask

	// Pulses rst_p for 4 cycles and counts the cycles until the system is released.
	task apply_reset(output int rel);
		int n;
		@(posedge clk);
		rst_p    <= 1'b1;
		pi1_op   <= pi1_pkg::PI1_OP_READ;
		pi1_addr <= soc_map_pkg::DEVTBL_BASE + 30'd1;
		repeat (3) @(posedge clk);
		@(posedge clk);
		rst_p <= 1'b0;
		n = 0;
		@(negedge clk);
		while (sys_rst_o === 1'b1 && n < 200) begin
			if (pi1_rdy_o !== 1'b0) begin
				err_cnt++;
				$display("Ready was raised while the system was in reset");
			end
			n++;
			@(posedge clk);
			if (n == 8) begin
				pi1_op <= pi1_pkg::PI1_OP_IDLE;
			end
			@(negedge clk);
		end
		@(posedge clk);
		pi1_op <= pi1_pkg::PI1_OP_IDLE;
		rel = n;
	endtask

	task wait_for_sys_rst(input string name, input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (sys_rst_o !== level && n < limit) begin
			n++;
			@(negedge clk);
		end
		if (sys_rst_o !== level) begin
			err_cnt++;
			$display("%s: system reset did not go %s in time", name, level ? "high" : "low");
		end
	endtask

	task wait_for_irq(input string name);
		int n;
		n = 0;
		@(negedge clk);
		while (gpio_irq_o !== 1'b1 && n < 10) begin
			n++;
			@(negedge clk);
		end
		if (gpio_irq_o !== 1'b1) begin
			err_cnt++;
			$display("%s: interrupt did not rise after an input change", name);
		end
	endtask

	task test_reset_table();
		pi1_pkg::pi1_data_t rd;
		int                 rel;
		int                 errs;
		errs = err_cnt;
		apply_reset(rel);
		check_data("reset", pi1_pkg::pi1_data_t'(RELEASE_CYCLES), pi1_pkg::pi1_data_t'(rel));
		// Word 0 is DT_CTRL and must read zero after reset.
		for (int w = 0; w < 16; w++) begin
			bus_read("devtbl", soc_map_pkg::DEVTBL_BASE + pi1_pkg::pi1_addr_t'(w), rd);
			check_data("devtbl", table_word(w), rd);
		end
		finish_test("reset", errs);
	endtask

	task test_gpio_out();
		pi1_pkg::pi1_data_t d;
		pi1_pkg::pi1_sel_t  s;
		pi1_pkg::pi1_data_t rd;
		int                 errs;
		errs = err_cnt;
		for (int i = 0; i < 8; i++) begin
			d = $urandom;
			s = pi1_pkg::pi1_sel_t'($urandom);
			bus_write("gpio_out", soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_OUT, d, s);
			for (int b = 0; b < GPIOCOUNT / 8; b++) begin
				if (s[b]) begin
					gp_model[b*8 +: 8] = d[b*8 +: 8];
				end
			end
			check_gpio("gpio_out", gp_model, gp_o);
			bus_read("gpio_out", soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_OUT, rd);
			check_data("gpio_out", pi1_pkg::pi1_data_t'(gp_model), rd);
		end
		d = $urandom;
		bus_swap("gpio_swap", soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_OUT, d, rd);
		check_data("gpio_swap", pi1_pkg::pi1_data_t'(gp_model), rd);
		gp_model = d[GPIOCOUNT-1:0];
		check_gpio("gpio_swap", gp_model, gp_o);
		finish_test("gpio_out", errs);
	endtask

	task test_gpio_in();
		gpio_vec_t          old_v;
		gpio_vec_t          new_v;
		pi1_pkg::pi1_data_t rd;
		int                 errs;
		errs = err_cnt;
		for (int i = 0; i < 4; i++) begin
			old_v = gp_in_model;
			new_v = gpio_vec_t'($urandom);
			if (new_v == old_v) begin
				new_v = ~old_v;
			end
			@(posedge clk);
			gp_i <= new_v;
			gp_in_model = new_v;
			wait_for_irq("gpio_in");
			bus_read("gpio_in", soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_IN, rd);
			check_data("gpio_in", pi1_pkg::pi1_data_t'(new_v), rd);
			bus_read("gpio_chg", soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_CHG, rd);
			check_data("gpio_chg", pi1_pkg::pi1_data_t'(old_v ^ new_v), rd);
			bus_read("gpio_chg", soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_CHG, rd);
			check_data("gpio_chg", '0, rd);
			check_bit("gpio_irq", 1'b0, gpio_irq_o);
		end
		finish_test("gpio_in", errs);
	endtask

	task test_invalid();
		pi1_pkg::pi1_data_t rd;
		int                 pulses;
		int                 first;
		int                 errs;
		errs = err_cnt;
		for (int i = 0; i < 6; i++) begin
			bus_read("invalid", random_unmapped(), rd);
			check_data("invalid", '0, rd);
		end
		for (int i = 0; i < 4; i++) begin
			bus_write("invalid_wr", random_unmapped(), $urandom, 4'hF);
		end
		check_gpio("invalid_wr", gp_model, gp_o);
		bus_read("invalid_wr", soc_map_pkg::DEVTBL_BASE + soc_map_pkg::DT_CTRL, rd);
		check_data("invalid_wr", '0, rd);
		// Mix slaves so the answer mux switches every cycle.
		burst_addr[0] = random_unmapped();
		burst_exp[0]  = '0;
		burst_addr[1] = soc_map_pkg::DEVTBL_BASE + 30'd1;
		burst_exp[1]  = table_word(1);
		burst_addr[2] = soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_OUT;
		burst_exp[2]  = pi1_pkg::pi1_data_t'(gp_model);
		burst_addr[3] = random_unmapped();
		burst_exp[3]  = '0;
		burst_addr[4] = soc_map_pkg::DEVTBL_BASE + 30'd6;
		burst_exp[4]  = table_word(6);
		run_burst("back2back", 5, pulses, first);
		finish_test("invalid", errs);
	endtask

	task test_sw_reset();
		pi1_pkg::pi1_data_t rd;
		int                 rel;
		int                 errs;
		errs = err_cnt;
		// Warm reset, then cold reset, which acts the same here.
		for (int v = 2; v <= 3; v++) begin
			bus_write("sw_reset", soc_map_pkg::GPIO_BASE + soc_map_pkg::GP_OUT, 32'h0000_A5C3, 4'h3);
			gp_model = 16'hA5C3;
			check_gpio("sw_reset", gp_model, gp_o);
			bus_write("sw_reset", soc_map_pkg::DEVTBL_BASE + soc_map_pkg::DT_CTRL,
				pi1_pkg::pi1_data_t'(v), 4'hF);
			wait_for_sys_rst("sw_reset", 1'b1, 10);
			wait_for_sys_rst("sw_reset", 1'b0, 40);
			gp_model = '0;
			check_gpio("sw_reset", gp_model, gp_o);
			bus_read("sw_reset", soc_map_pkg::DEVTBL_BASE + soc_map_pkg::DT_CTRL, rd);
			check_data("sw_reset", '0, rd);
		end
		bus_write("power_off", soc_map_pkg::DEVTBL_BASE + soc_map_pkg::DT_CTRL, 32'd1, 4'hF);
		wait_for_sys_rst("power_off", 1'b1, 10);
		for (int i = 0; i < 100; i++) begin
			@(negedge clk);
			check_bit("power_off", 1'b1, sys_rst_o);
		end
		apply_reset(rel);
		check_data("power_off", pi1_pkg::pi1_data_t'(RELEASE_CYCLES), pi1_pkg::pi1_data_t'(rel));
		check_gpio("power_off", gp_model, gp_o);
		bus_read("power_off", soc_map_pkg::DEVTBL_BASE + soc_map_pkg::DT_CTRL, rd);
		check_data("power_off", '0, rd);
		finish_test("sw_reset", errs);
	endtask

	task test_activity();
		pi1_pkg::pi1_data_t rd;
		int                 pulses;
		int                 first;
		int                 errs;
		errs = err_cnt;
		// Let the hold-off counter drain before the burst.
		repeat (8) @(posedge clk);
		for (int k = 0; k < 6; k++) begin
			burst_addr[k] = soc_map_pkg::DEVTBL_BASE + pi1_pkg::pi1_addr_t'(k + 1);
			burst_exp[k]  = table_word(k + 1);
		end
		run_burst("activity", 6, pulses, first);
		check_data("activity", 32'd1, pi1_pkg::pi1_data_t'(pulses));
		check_data("activity", 32'd0, pi1_pkg::pi1_data_t'(first));
		repeat (8) @(posedge clk);
		bus_read("activity", soc_map_pkg::DEVTBL_BASE + 30'd2, rd);
		check_bit("activity", 1'b1, activity_o);
		finish_test("activity", errs);
	endtask

	initial begin
		rst_p       = 1'b1;
		pi1_op      = pi1_pkg::PI1_OP_IDLE;
		pi1_addr    = '0;
		pi1_wdata   = '0;
		pi1_sel     = '0;
		gp_i        = '0;
		gp_model    = '0;
		gp_in_model = '0;
		err_cnt     = 0;
		check_cnt   = 0;
		test_cnt    = 0;
		void'($urandom(SEED));
		test_reset_table();
		test_gpio_out();
		test_gpio_in();
		test_invalid();
		test_sw_reset();
		test_activity();
		$display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- hw/soc_top.sv
//------------------------------
// SoC housekeeping top: reset sequencer,
// PI1 decoder, slaves, activity dimmer.
//------------------------------

`timescale 1ns/100ps

module soc_top #(
	parameter int RST_CNTR_BITSZ      = 16,
	parameter int ACTIVITY_CNTR_BITSZ = 7,
	parameter int GPIOCOUNT           = 16
) (
	input  logic                 clk100mhz_i,
	input  logic                 rst_p,
	input  pi1_pkg::pi1_op_e     pi1_op_i,
	input  pi1_pkg::pi1_addr_t   pi1_addr_i,
	input  pi1_pkg::pi1_data_t   pi1_data_i,
	input  pi1_pkg::pi1_sel_t    pi1_sel_i,
	input  logic [GPIOCOUNT-1:0] gp_i,
	output pi1_pkg::pi1_data_t   pi1_data_o,
	output logic                 pi1_rdy_o,
	output logic [GPIOCOUNT-1:0] gp_o,
	output logic                 gpio_irq_o,
	output logic                 sys_rst_o,
	output logic                 activity_o
);

	logic sys_rst;
	logic sw_rst0;
	logic sw_rst1;

	logic [ACTIVITY_CNTR_BITSZ-1:0] activity_cntr_q;

	pi1_if devtbl_bus ();
	pi1_if gpio_bus ();

	rst_seq #(
		.RST_CNTR_BITSZ (RST_CNTR_BITSZ)
	) i_rst_seq (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.sw_rst0_i   (sw_rst0),
		.sw_rst1_i   (sw_rst1),
		.sys_rst_o   (sys_rst)
	);

	pi1_decoder i_pi1_decoder (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (sys_rst),
		.op_i        (pi1_op_i),
		.addr_i      (pi1_addr_i),
		.data_i      (pi1_data_i),
		.sel_i       (pi1_sel_i),
		.data_o      (pi1_data_o),
		.rdy_o       (pi1_rdy_o),
		.devtbl_bus  (devtbl_bus.master),
		.gpio_bus    (gpio_bus.master)
	);

	devtbl i_devtbl (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (sys_rst),
		.bus         (devtbl_bus.slave),
		.sw_rst0_o   (sw_rst0),
		.sw_rst1_o   (sw_rst1)
	);

	gpio #(
		.GPIOCOUNT (GPIOCOUNT)
	) i_gpio (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (sys_rst),
		.gp_i        (gp_i),
		.bus         (gpio_bus.slave),
		.gp_o        (gp_o),
		.irq_o       (gpio_irq_o)
	);

	// Hold-off counter dims the indicator: one pulse per window.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst) begin
			activity_cntr_q <= '0;
		end else if (|activity_cntr_q) begin
			activity_cntr_q <= activity_cntr_q - 1'b1;
		end else if (pi1_rdy_o) begin
			activity_cntr_q <= '1;
		end
	end

	assign activity_o = pi1_rdy_o && (activity_cntr_q == '0);
	assign sys_rst_o  = sys_rst;

endmodule

//--- hw/gpio.sv
//------------------------------
// GPIO slave with input-change interrupt.
//------------------------------

`timescale 1ns/100ps

module gpio #(
	// At most one bus word of pins.
	parameter int GPIOCOUNT = 16
) (
	input  logic                 clk100mhz_i,
	input  logic                 rst_p,
	input  logic [GPIOCOUNT-1:0] gp_i,
	pi1_if.slave                 bus,
	output logic [GPIOCOUNT-1:0] gp_o,
	output logic                 irq_o
);

	logic [GPIOCOUNT-1:0] sync1_q;
	logic [GPIOCOUNT-1:0] sync2_q;
	logic [GPIOCOUNT-1:0] prev_q;
	logic [GPIOCOUNT-1:0] chg_q;
	logic [GPIOCOUNT-1:0] out_q;
	logic                 irq_q;
	logic                 rdy_q;
	logic                 wr_out;
	logic                 clr_chg;
	pi1_pkg::pi1_data_t   out_merged;
	pi1_pkg::pi1_data_t   rd_word;
	pi1_pkg::pi1_data_t   rdata_q;

	// Two-flop synchronizer, then a copy for edge detection.
	always_ff @(posedge clk100mhz_i) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	assign wr_out = (bus.addr == soc_map_pkg::GP_OUT) &&
		((bus.op == pi1_pkg::PI1_OP_WRITE) || (bus.op == pi1_pkg::PI1_OP_SWAP));
	assign clr_chg = (bus.addr == soc_map_pkg::GP_CHG) &&
		((bus.op == pi1_pkg::PI1_OP_READ) || (bus.op == pi1_pkg::PI1_OP_SWAP));

	// Byte lanes not selected keep their old value.
	always_comb begin
		out_merged = pi1_pkg::pi1_data_t'(out_q);
		for (int b = 0; b < pi1_pkg::ARCHBITSZ / 8; b++) begin
			if (bus.sel[b]) begin
				out_merged[b*8 +: 8] = bus.wdata[b*8 +: 8];
			end
		end
	end

	always_comb begin
		case (bus.addr)
			soc_map_pkg::GP_IN:  rd_word = pi1_pkg::pi1_data_t'(sync2_q);
			soc_map_pkg::GP_OUT: rd_word = pi1_pkg::pi1_data_t'(out_q);
			soc_map_pkg::GP_CHG: rd_word = pi1_pkg::pi1_data_t'(chg_q);
			default:             rd_word = '0;
		endcase
	end

	// A change seen in the clearing cycle survives the clear.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			out_q <= '0;
			chg_q <= '0;
			irq_q <= 1'b0;
			rdy_q <= 1'b0;
		end else begin
			if (wr_out) begin
				out_q <= out_merged[GPIOCOUNT-1:0];
			end
			chg_q <= (clr_chg ? '0 : chg_q) | (sync2_q ^ prev_q);
			irq_q <= |chg_q;
			rdy_q <= (bus.op != pi1_pkg::PI1_OP_IDLE);
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (bus.op != pi1_pkg::PI1_OP_IDLE) begin
			rdata_q <= rd_word;
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy   = rdy_q;
	assign gp_o      = out_q;
	assign irq_o     = irq_q;

	// A synchronized input change raises the interrupt two cycles later.
	a_irq_status: assert property (@(posedge clk100mhz_i)
		(!rst_p && (sync2_q != prev_q)) ##1 !rst_p |=> irq_o);

endmodule

//--- hw/devtbl.sv
//------------------------------
// Device table and software reset register.
//------------------------------

`timescale 1ns/100ps

module devtbl (
	input  logic  clk100mhz_i,
	input  logic  rst_p,
	pi1_if.slave  bus,
	output logic  sw_rst0_o,
	output logic  sw_rst1_o
);

	logic [1:0]         rst_bits_q;
	pi1_pkg::pi1_data_t rd_word;
	pi1_pkg::pi1_data_t rdata_q;
	logic               rdy_q;
	logic               wr_en;

	// Table lookup; unused words read as zero.
	always_comb begin
		rd_word = '0;
		if (bus.addr == soc_map_pkg::DT_CTRL) begin
			rd_word = {30'd0, rst_bits_q};
		end
		for (int k = 0; k < soc_map_pkg::SLAVECOUNT; k++) begin
			if (bus.addr == soc_map_pkg::DT_ENTRY + pi1_pkg::pi1_addr_t'(2 * k)) begin
				rd_word = {soc_map_pkg::DEV_ID[k], soc_map_pkg::DEV_USEINTR[k]};
			end
			if (bus.addr == soc_map_pkg::DT_ENTRY + pi1_pkg::pi1_addr_t'(2 * k + 1)) begin
				rd_word = {2'b00, soc_map_pkg::DEV_MAPSZ[k]};
			end
		end
	end

	assign wr_en = (bus.op == pi1_pkg::PI1_OP_WRITE) || (bus.op == pi1_pkg::PI1_OP_SWAP);

	// Reset bits clear themselves through the system reset they request.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			rst_bits_q <= 2'b00;
		end else if (wr_en && (bus.addr == soc_map_pkg::DT_CTRL)) begin
			rst_bits_q <= bus.wdata[1:0];
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= (bus.op != pi1_pkg::PI1_OP_IDLE);
		end
	end

	// A swap returns the value from before the write.
	always_ff @(posedge clk100mhz_i) begin
		if (bus.op != pi1_pkg::PI1_OP_IDLE) begin
			rdata_q <= rd_word;
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy   = rdy_q;
	assign sw_rst0_o = rst_bits_q[0];
	assign sw_rst1_o = rst_bits_q[1];

endmodule

//--- hw/pi1_decoder.sv
//------------------------------
// PI1 decoder: address routing, answer mux
// and the invalid-address responder.
//------------------------------

`timescale 1ns/100ps

module pi1_decoder (
	input  logic               clk100mhz_i,
	input  logic               rst_p,
	input  pi1_pkg::pi1_op_e   op_i,
	input  pi1_pkg::pi1_addr_t addr_i,
	input  pi1_pkg::pi1_data_t data_i,
	input  pi1_pkg::pi1_sel_t  sel_i,
	output pi1_pkg::pi1_data_t data_o,
	output logic               rdy_o,
	pi1_if.master              devtbl_bus,
	pi1_if.master              gpio_bus
);

	pi1_pkg::pi1_addr_t dt_off;
	pi1_pkg::pi1_addr_t gp_off;
	logic               dt_hit;
	logic               gp_hit;

	soc_map_pkg::slave_idx_t req_idx;
	soc_map_pkg::slave_idx_t ans_idx_q;
	logic                    inv_rdy_q;

	// Offsets within each window; a wrapped offset falls outside the window.
	assign dt_off = addr_i - soc_map_pkg::DEVTBL_BASE;
	assign gp_off = addr_i - soc_map_pkg::GPIO_BASE;
	assign dt_hit = (dt_off < soc_map_pkg::DEVTBL_MAPSZ);
	assign gp_hit = (gp_off < soc_map_pkg::GPIO_MAPSZ);

	always_comb begin
		if (dt_hit) begin
			req_idx = soc_map_pkg::S_DEVTBL;
		end else if (gp_hit) begin
			req_idx = soc_map_pkg::S_GPIO;
		end else begin
			req_idx = soc_map_pkg::S_INVALID;
		end
	end

	// Only the selected slave sees the strobe.
	assign devtbl_bus.op    = (req_idx == soc_map_pkg::S_DEVTBL) ? op_i : pi1_pkg::PI1_OP_IDLE;
	assign devtbl_bus.addr  = dt_off;
	assign devtbl_bus.wdata = data_i;
	assign devtbl_bus.sel   = sel_i;

	assign gpio_bus.op    = (req_idx == soc_map_pkg::S_GPIO) ? op_i : pi1_pkg::PI1_OP_IDLE;
	assign gpio_bus.addr  = gp_off;
	assign gpio_bus.wdata = data_i;
	assign gpio_bus.sel   = sel_i;

	// Remember who answers next cycle. The default responder drops writes.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			ans_idx_q <= soc_map_pkg::S_INVALID;
			inv_rdy_q <= 1'b0;
		end else begin
			ans_idx_q <= req_idx;
			inv_rdy_q <= (op_i != pi1_pkg::PI1_OP_IDLE) &&
				(req_idx == soc_map_pkg::S_INVALID);
		end
	end

	always_comb begin
		case (ans_idx_q)
			soc_map_pkg::S_DEVTBL: begin
				data_o = devtbl_bus.rdata;
				rdy_o  = devtbl_bus.rdy;
			end
			soc_map_pkg::S_GPIO: begin
				data_o = gpio_bus.rdata;
				rdy_o  = gpio_bus.rdy;
			end
			default: begin
				data_o = '0;
				rdy_o  = inv_rdy_q;
			end
		endcase
	end

	// Routing keeps answers from different slaves apart.
	a_one_rdy: assert property (@(posedge clk100mhz_i)
		$onehot0({devtbl_bus.rdy, gpio_bus.rdy, inv_rdy_q}));

endmodule

//--- hw/rst_seq.sv
//------------------------------
// Reset sequencer: stretch counter,
// software resets and power-off latch.
//------------------------------

`timescale 1ns/100ps

module rst_seq #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic sw_rst0_i,
	input  logic sw_rst1_i,
	output logic sys_rst_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr_q;
	logic                      pwroff_q;

	logic sw_warm;
	logic sw_cold;
	logic sw_pwroff;

	// Meaning of the two devtbl reset bits.
	assign sw_warm   = !sw_rst0_i && sw_rst1_i;
	assign sw_cold   = sw_rst0_i && sw_rst1_i;
	assign sw_pwroff = sw_rst0_i && !sw_rst1_i;

	// Any reset source reloads the counter, which then drains to zero.
	// Without a device-wide reset primitive a cold reset behaves as a warm one.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || sw_warm || sw_cold) begin
			rst_cntr_q <= '1;
		end else if (|rst_cntr_q) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off holds the system in reset until the external reset.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (|rst_cntr_q) || pwroff_q;

	// A power-off request puts the system in reset on the following cycle.
	a_pwroff_holds: assert property (@(posedge clk100mhz_i)
		(sw_pwroff && !rst_p) |=> sys_rst_o);

endmodule

//--- hw/pi1_if.sv
//------------------------------
// PI1 link from the decoder to one slave.
//------------------------------

`timescale 1ns/100ps

interface pi1_if;

	// Request, driven by the decoder.
	pi1_pkg::pi1_op_e   op;
	pi1_pkg::pi1_addr_t addr;
	pi1_pkg::pi1_data_t wdata;
	pi1_pkg::pi1_sel_t  sel;

	// Answer, one cycle after the request.
	pi1_pkg::pi1_data_t rdata;
	logic               rdy;

	modport master (
		output op, addr, wdata, sel,
		input  rdata, rdy
	);

	modport slave (
		input  op, addr, wdata, sel,
		output rdata, rdy
	);

endinterface

//--- hw/soc_map_pkg.sv
//------------------------------
// Address map: slave indices, windows,
// device IDs and register offsets.
//------------------------------

package soc_map_pkg;

	// Index of each slave on the decoder.
	typedef logic [1:0] slave_idx_t;

	localparam slave_idx_t S_DEVTBL  = 2'd0;
	localparam slave_idx_t S_GPIO    = 2'd1;
	localparam slave_idx_t S_INVALID = 2'd2;
	localparam int SLAVECOUNT = 3;

	// Base word addresses.
	localparam pi1_pkg::pi1_addr_t DEVTBL_BASE = 30'd0;
	localparam pi1_pkg::pi1_addr_t GPIO_BASE   = 30'd16;

	// Window sizes in words.
	localparam pi1_pkg::pi1_addr_t DEVTBL_MAPSZ  = 30'd16;
	localparam pi1_pkg::pi1_addr_t GPIO_MAPSZ    = 30'd4;
	localparam pi1_pkg::pi1_addr_t INVALID_MAPSZ = 30'd1024;

	// Device IDs as reported in bits 31:1 of a table word.
	typedef logic [30:0] dev_id_t;

	// Table contents, ordered by slave index.
	localparam dev_id_t DEV_ID [SLAVECOUNT] = '{31'd7, 31'd6, 31'd0};
	localparam logic DEV_USEINTR [SLAVECOUNT] = '{1'b0, 1'b1, 1'b0};
	localparam pi1_pkg::pi1_addr_t DEV_MAPSZ [SLAVECOUNT] =
		'{DEVTBL_MAPSZ, GPIO_MAPSZ, INVALID_MAPSZ};

	// Devtbl word offsets; entry k sits at DT_ENTRY+2k and DT_ENTRY+2k+1.
	localparam pi1_pkg::pi1_addr_t DT_CTRL  = 30'd0;
	localparam pi1_pkg::pi1_addr_t DT_ENTRY = 30'd1;

	// GPIO word offsets.
	localparam pi1_pkg::pi1_addr_t GP_IN  = 30'd0;
	localparam pi1_pkg::pi1_addr_t GP_OUT = 30'd1;
	localparam pi1_pkg::pi1_addr_t GP_CHG = 30'd2;

endpackage

//--- hw/pi1_pkg.sv
//------------------------------
// PI1 bus definitions: op codes
// and the word, address and byte-select types.
//------------------------------

package pi1_pkg;

	// Architecture width that sizes every bus vector.
	localparam int ARCHBITSZ = 32;

	// Number of byte-offset bits dropped from a word address.
	localparam int BYTEOFFBITSZ = $clog2(ARCHBITSZ / 8);

	// Bus operation issued by the master for one cycle.
	typedef enum logic [1:0] {
		PI1_OP_IDLE  = 2'b00,
		PI1_OP_WRITE = 2'b01,
		PI1_OP_READ  = 2'b10,
		// Read the old value, then write the new one.
		PI1_OP_SWAP  = 2'b11
	} pi1_op_e;

	// One bus word.
	typedef logic [ARCHBITSZ-1:0] pi1_data_t;

	// Word address.
	typedef logic [ARCHBITSZ-BYTEOFFBITSZ-1:0] pi1_addr_t;

	// Byte enables of a write.
	typedef logic [(ARCHBITSZ/8)-1:0] pi1_sel_t;

endpackage
